//--- sim.f
verilog/csr_pkg.sv
verilog/csr_bus_if.sv
verilog/exc_if.sv
verilog/csr_exc_regs.sv
verilog/csr_timer.sv
verilog/csr_save_bank.sv
verilog/csr_top.sv
verif/csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;
    localparam int XLEN       = csr_pkg::XLEN;
    localparam int SAVE_COUNT = 4;
    // twice the edge count of reset and the six tests
    localparam int MAX_CYCLES = (4 + 27 + 14 + 9 + 13 + 19 + 26) * 2;

    logic                           clk = 1'b0;
    logic                           reset;
    logic [csr_pkg::CSR_NUM_W-1:0]  csr_num;
    logic                           csr_we;
    logic [XLEN-1:0]                csr_wmask;
    logic [XLEN-1:0]                csr_wvalue;
    logic [XLEN-1:0]                csr_rvalue;
    logic                           wb_ex;
    logic                           ertn_flush;
    logic [csr_pkg::ECODE_W-1:0]    wb_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] wb_esubcode;
    logic [XLEN-1:0]                wb_pc;
    logic [XLEN-1:0]                wb_vaddr;
    logic                           has_int;
    logic [XLEN-1:0]                ex_entry;
    logic [XLEN-1:0]                ertn_entry;
    logic [csr_pkg::PLV_W-1:0]      crmd_plv;
    logic [csr_pkg::ECODE_W-1:0]    estat_ecode;

    int          errors     = 0;
    int          cycles     = 0;
    logic [31:0] lfsr_state = 32'h0f93c2bd;

    csr_top #(.SAVE_COUNT(SAVE_COUNT)) dut_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d", errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic check_word(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_plv(input string name, input logic [csr_pkg::PLV_W-1:0] exp,
                             input logic [csr_pkg::PLV_W-1:0] act);
        if (act !== exp) begin
            $display("Error %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic csr_write(input logic [csr_pkg::CSR_NUM_W-1:0] num,
                             input logic [XLEN-1:0] mask, input logic [XLEN-1:0] value);
        @(posedge clk);
        csr_num    <= num;
        csr_we     <= 1'b1;
        csr_wmask  <= mask;
        csr_wvalue <= value;
        @(posedge clk);
        csr_we <= 1'b0;  // captured at this edge
    endtask

    task automatic csr_read(input logic [csr_pkg::CSR_NUM_W-1:0] num,
                            output logic [XLEN-1:0] data);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        data = csr_rvalue;
    endtask

    task automatic raise_exception(input logic [csr_pkg::ECODE_W-1:0] ecode,
                                   input logic [csr_pkg::ESUBCODE_W-1:0] esub,
                                   input logic [XLEN-1:0] pc, input logic [XLEN-1:0] vaddr);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= ecode;
        wb_esubcode <= esub;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        @(posedge clk);
        wb_ex <= 1'b0;
    endtask

    task automatic pulse_ertn();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic reset_and_save_regs();
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] first;
        logic [XLEN-1:0] mask;
        logic [XLEN-1:0] value;
        csr_read(csr_pkg::CSR_CRMD, rd);
        check_word("crmd", '0, rd);
        csr_read(csr_pkg::CSR_ECFG, rd);
        check_word("ecfg", '0, rd);
        csr_read(csr_pkg::CSR_TID, rd);
        check_word("tid", '0, rd);
        csr_read(csr_pkg::CSR_ESTAT, rd);
        check_word("estat.is", '0, rd & 32'h1fff);
        csr_read(csr_pkg::CSR_TVAL, rd);
        check_word("tval", '1, rd);
        check_bit("has_int", 1'b0, has_int);
        for (int i = 0; i < SAVE_COUNT; i++) begin
            first = rand_bits(32);
            mask  = rand_bits(32);
            value = rand_bits(32);
            // save regs start unknown so fill fully first
            csr_write(csr_pkg::CSR_SAVE_BASE + 14'(i), '1, first);
            csr_write(csr_pkg::CSR_SAVE_BASE + 14'(i), mask, value);
            csr_read(csr_pkg::CSR_SAVE_BASE + 14'(i), rd);
            check_word($sformatf("save%0d", i), (mask & value) | (~mask & first), rd);
        end
        csr_read(csr_pkg::CSR_SAVE_BASE + 14'(SAVE_COUNT), rd);
        check_word("save beyond count", '0, rd);
        csr_read(14'h2, rd);
        check_word("unknown number 0x2", '0, rd);
    endtask

    task automatic exception_entry_return();
        logic [XLEN-1:0]                rd;
        logic [XLEN-1:0]                eentry;
        logic [XLEN-1:0]                pc;
        logic [XLEN-1:0]                r;
        logic [csr_pkg::ECODE_W-1:0]    ecode;
        logic [csr_pkg::ESUBCODE_W-1:0] esub;
        eentry = rand_bits(32);
        pc     = rand_bits(32);
        r      = rand_bits(6);
        ecode  = r[5:0];
        r      = rand_bits(9);
        esub   = r[8:0];
        csr_write(csr_pkg::CSR_CRMD, '1, 32'h7);  // plv 3 and ie 1
        csr_write(csr_pkg::CSR_EENTRY, '1, eentry);
        csr_read(csr_pkg::CSR_CRMD, rd);
        check_word("crmd before ex", 32'h7, rd);
        raise_exception(ecode, esub, pc, rand_bits(32));
        csr_read(csr_pkg::CSR_CRMD, rd);
        check_word("crmd after ex", '0, rd);
        check_plv("crmd_plv after ex", 2'd0, crmd_plv);
        csr_read(csr_pkg::CSR_PRMD, rd);
        check_word("prmd", 32'h7, rd);
        csr_read(csr_pkg::CSR_ERA, rd);
        check_word("era", pc, rd);
        csr_read(csr_pkg::CSR_ESTAT, rd);
        check_word("estat.ecode", XLEN'(ecode), XLEN'(rd[21:16]));
        check_word("estat.esubcode", XLEN'(esub), XLEN'(rd[30:22]));
        check_word("estat_ecode", XLEN'(ecode), XLEN'(estat_ecode));
        check_word("ex_entry", {eentry[31:6], 6'b0}, ex_entry);
        pulse_ertn();
        csr_read(csr_pkg::CSR_CRMD, rd);
        check_word("crmd after ertn", 32'h7, rd);
        check_plv("crmd_plv after ertn", 2'd3, crmd_plv);
        check_word("ertn_entry", pc, ertn_entry);
    endtask

    task automatic badv_capture();
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] ale_va;
        logic [XLEN-1:0] ade_va;
        ale_va = rand_bits(32);
        ade_va = rand_bits(32);
        raise_exception(csr_pkg::ECODE_ALE, '0, rand_bits(32), ale_va);
        csr_read(csr_pkg::CSR_BADV, rd);
        check_word("badv after ale", ale_va, rd);
        raise_exception(csr_pkg::ECODE_ADE, '0, rand_bits(32), ade_va);
        csr_read(csr_pkg::CSR_BADV, rd);
        check_word("badv after ade", ade_va, rd);
        raise_exception(6'h1, '0, rand_bits(32), rand_bits(32));  // not an address error
        csr_read(csr_pkg::CSR_BADV, rd);
        check_word("badv kept", ade_va, rd);
    endtask

    task automatic interrupt_request();
        logic [XLEN-1:0] rd;
        csr_write(csr_pkg::CSR_ECFG, '1, '1);
        csr_read(csr_pkg::CSR_ECFG, rd);
        check_word("ecfg", 32'h0000_1bff, rd);
        csr_write(csr_pkg::CSR_CRMD, '1, '0);
        csr_write(csr_pkg::CSR_ESTAT, 32'h1, 32'h1);  // software bit 0
        @(negedge clk);
        check_bit("has_int with ie 0", 1'b0, has_int);
        csr_write(csr_pkg::CSR_CRMD, 32'h4, 32'h4);
        @(negedge clk);
        check_bit("has_int with ie 1", 1'b1, has_int);
        csr_write(csr_pkg::CSR_ECFG, 32'h1, 32'h0);
        @(negedge clk);
        check_bit("has_int with lie 0", 1'b0, has_int);
        csr_write(csr_pkg::CSR_ESTAT, 32'h1, 32'h0);
    endtask

    task automatic oneshot_timer();
        logic [XLEN-1:0] rd;
        int              iv;
        int              period;
        iv     = 3;
        period = 4 * iv + 1;
        csr_write(csr_pkg::CSR_TCFG, '1, {30'(iv), 2'b01});
        csr_num <= csr_pkg::CSR_ESTAT;
        for (int k = 1; k <= period; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit($sformatf("estat.is[11] edge %0d", k), k == period,
                      csr_rvalue[csr_pkg::TI_BIT]);
        end
        csr_read(csr_pkg::CSR_TVAL, rd);
        check_word("tval after one-shot", '1, rd);
        csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        csr_read(csr_pkg::CSR_ESTAT, rd);
        check_bit("estat.is[11] after ticlr", 1'b0, rd[csr_pkg::TI_BIT]);
    endtask

    // has_int follows ti_pending with only lie bit 11 and ie set
    task automatic periodic_timer();
        int iv;
        int period;
        iv     = 2;
        period = 4 * iv + 1;
        csr_write(csr_pkg::CSR_ECFG, '1, 32'h800);
        csr_write(csr_pkg::CSR_CRMD, '1, 32'h4);
        csr_write(csr_pkg::CSR_TCFG, '1, {30'(iv), 2'b11});
        csr_num <= csr_pkg::CSR_TVAL;
        for (int k = 1; k <= period; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit($sformatf("has_int edge %0d", k), k == period, has_int);
        end
        check_word("tval reload", XLEN'(4 * iv), csr_rvalue);
        csr_write(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        csr_num <= csr_pkg::CSR_TVAL;
        @(negedge clk);
        check_bit("has_int after ticlr", 1'b0, has_int);
        for (int k = period + 3; k <= 2 * period; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_bit($sformatf("has_int edge %0d", k), k == 2 * period, has_int);
        end
        check_word("tval second reload", XLEN'(4 * iv), csr_rvalue);
        csr_write(csr_pkg::CSR_TCFG, '1, '0);
    endtask

    initial begin
        reset       <= 1'b1;
        csr_num     <= '0;
        csr_we      <= 1'b0;
        csr_wmask   <= '0;
        csr_wvalue  <= '0;
        wb_ex       <= 1'b0;
        ertn_flush  <= 1'b0;
        wb_ecode    <= '0;
        wb_esubcode <= '0;
        wb_pc       <= '0;
        wb_vaddr    <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_and_save_regs();
        exception_entry_return();
        badv_capture();
        interrupt_request();
        oneshot_timer();
        periodic_timer();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog/csr_top.sv
`timescale 1ns/1ns

module csr_top #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [csr_pkg::CSR_NUM_W-1:0]  csr_num,
    input  logic                           csr_we,
    input  logic [csr_pkg::XLEN-1:0]       csr_wmask,
    input  logic [csr_pkg::XLEN-1:0]       csr_wvalue,
    output logic [csr_pkg::XLEN-1:0]       csr_rvalue,
    input  logic                           wb_ex,
    input  logic                           ertn_flush,
    input  logic [csr_pkg::ECODE_W-1:0]    wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0] wb_esubcode,
    input  logic [csr_pkg::XLEN-1:0]       wb_pc,
    input  logic [csr_pkg::XLEN-1:0]       wb_vaddr,
    output logic                           has_int,
    output logic [csr_pkg::XLEN-1:0]       ex_entry,
    output logic [csr_pkg::XLEN-1:0]       ertn_entry,
    output logic [csr_pkg::PLV_W-1:0]      crmd_plv,
    output logic [csr_pkg::ECODE_W-1:0]    estat_ecode
);
    logic [csr_pkg::XLEN-1:0] exc_rdata;
    logic [csr_pkg::XLEN-1:0] timer_rdata;
    logic [csr_pkg::XLEN-1:0] save_rdata;
    logic                     ti_pending;

    csr_bus_if bus ();
    exc_if     exc ();

    assign bus.num    = csr_num;
    assign bus.we     = csr_we;
    assign bus.wmask  = csr_wmask;
    assign bus.wvalue = csr_wvalue;

    assign exc.ex       = wb_ex;
    assign exc.ertn     = ertn_flush;
    assign exc.ecode    = wb_ecode;
    assign exc.esubcode = wb_esubcode;
    assign exc.pc       = wb_pc;
    assign exc.vaddr    = wb_vaddr;

    csr_exc_regs exc_regs_i (
        .clk(clk), .reset(reset), .bus(bus.slave), .exc(exc.sink),
        .ti_pending(ti_pending), .rdata(exc_rdata), .has_int(has_int),
        .ex_entry(ex_entry), .ertn_entry(ertn_entry),
        .crmd_plv(crmd_plv), .estat_ecode(estat_ecode)
    );

    csr_timer timer_i (
        .clk(clk), .reset(reset), .bus(bus.slave),
        .rdata(timer_rdata), .ti_pending(ti_pending)
    );

    csr_save_bank #(.SAVE_COUNT(SAVE_COUNT)) save_bank_i (
        .clk(clk), .bus(bus.slave), .rdata(save_rdata)
    );

    // blocks return zero for numbers they do not own
    assign csr_rvalue = exc_rdata | timer_rdata | save_rdata;

endmodule

//--- verilog/csr_save_bank.sv
`timescale 1ns/1ns

module csr_save_bank #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                     clk,
    csr_bus_if.slave                 bus,
    output logic [csr_pkg::XLEN-1:0] rdata
);
    logic [csr_pkg::XLEN-1:0] save_q [SAVE_COUNT];

    function automatic logic [csr_pkg::CSR_NUM_W-1:0] save_num(input int idx);
        save_num = csr_pkg::CSR_SAVE_BASE + idx[csr_pkg::CSR_NUM_W-1:0];
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (bus.we && bus.num == save_num(i))
                save_q[i] <= (bus.wmask & bus.wvalue) | (~bus.wmask & save_q[i]);
        end
    end

    always_comb begin
        rdata = '0;
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (bus.num == save_num(i))
                rdata = save_q[i];
        end
    end

    assert property (@(posedge clk)
        SAVE_COUNT >= 1 && SAVE_COUNT <= csr_pkg::SAVE_COUNT_MAX);

endmodule

//--- verilog/csr_timer.sv
`timescale 1ns/1ns

module csr_timer (
    input  logic                     clk,
    input  logic                     reset,
    csr_bus_if.slave                 bus,
    output logic [csr_pkg::XLEN-1:0] rdata,
    output logic                     ti_pending
);
    localparam int IV_W = csr_pkg::XLEN - csr_pkg::TCFG_INITVAL_LSB;

    logic [csr_pkg::XLEN-1:0] tid_q;
    logic [csr_pkg::XLEN-1:0] cnt;
    logic [csr_pkg::XLEN-1:0] merged;
    logic                     tcfg_en;
    logic                     tcfg_periodic;
    logic [IV_W-1:0]          tcfg_initval;
    logic                     tcfg_wr;
    logic                     ticlr_wr;

    assign merged   = (bus.wmask & bus.wvalue) | (~bus.wmask & rdata);
    assign tcfg_wr  = bus.we && bus.num == csr_pkg::CSR_TCFG;
    assign ticlr_wr = bus.we && bus.num == csr_pkg::CSR_TICLR
                      && bus.wmask[csr_pkg::TICLR_CLR_BIT] && bus.wvalue[csr_pkg::TICLR_CLR_BIT];

    always_ff @(posedge clk) begin
        if (reset)
            tid_q <= '0;
        else if (bus.we && bus.num == csr_pkg::CSR_TID)
            tid_q <= merged;
    end

    always_ff @(posedge clk) begin
        if (reset)
            tcfg_en <= 1'b0;
        else if (tcfg_wr)
            tcfg_en <= merged[csr_pkg::TCFG_EN_BIT];
        if (tcfg_wr) begin
            tcfg_periodic <= merged[csr_pkg::TCFG_PERIODIC_BIT];
            tcfg_initval  <= merged[csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB];
        end
    end

    // count is initval*4, stops at the idle value
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= csr_pkg::TIMER_IDLE;
        end else if (tcfg_wr && merged[csr_pkg::TCFG_EN_BIT]) begin
            cnt <= {merged[csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB],
                    {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
        end else if (tcfg_en && cnt != csr_pkg::TIMER_IDLE) begin
            if (cnt == '0 && tcfg_periodic)
                cnt <= {tcfg_initval, {csr_pkg::TCFG_INITVAL_LSB{1'b0}}};
            else
                cnt <= cnt - 1'b1;  // one-shot wraps to idle
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            ti_pending <= 1'b0;
        else if (tcfg_en && cnt == '0)
            ti_pending <= 1'b1;  // set beats clear
        else if (ticlr_wr)
            ti_pending <= 1'b0;
    end

    always_comb begin
        rdata = '0;
        case (bus.num)
            csr_pkg::CSR_TID:  rdata = tid_q;
            csr_pkg::CSR_TCFG: begin
                rdata[csr_pkg::TCFG_EN_BIT]       = tcfg_en;
                rdata[csr_pkg::TCFG_PERIODIC_BIT] = tcfg_periodic;
                rdata[csr_pkg::XLEN-1:csr_pkg::TCFG_INITVAL_LSB] = tcfg_initval;
            end
            csr_pkg::CSR_TVAL: rdata = cnt;
            default:           rdata = '0;  // ticlr reads zero
        endcase
    end

    assert property (@(posedge clk) disable iff (reset)
        !tcfg_en && !tcfg_wr |=> $stable(cnt));

endmodule

//--- verilog/csr_exc_regs.sv
`timescale 1ns/1ns

module csr_exc_regs (
    input  logic                           clk,
    input  logic                           reset,
    csr_bus_if.slave                       bus,
    exc_if.sink                            exc,
    input  logic                           ti_pending,
    output logic [csr_pkg::XLEN-1:0]       rdata,
    output logic                           has_int,
    output logic [csr_pkg::XLEN-1:0]       ex_entry,
    output logic [csr_pkg::XLEN-1:0]       ertn_entry,
    output logic [csr_pkg::PLV_W-1:0]      crmd_plv,
    output logic [csr_pkg::ECODE_W-1:0]    estat_ecode
);
    logic                                             crmd_ie;
    logic [csr_pkg::PLV_W-1:0]                        prmd_pplv;
    logic                                             prmd_pie;
    logic [csr_pkg::INT_W-1:0]                        ecfg_lie;
    logic [csr_pkg::SWI_W-1:0]                        estat_swi;
    logic [csr_pkg::INT_W-1:0]                        estat_is;
    logic [csr_pkg::ESUBCODE_W-1:0]                   estat_esubcode;
    logic [csr_pkg::XLEN-1:0]                         era;
    logic [csr_pkg::XLEN-1:0]                         badv;
    logic [csr_pkg::XLEN-csr_pkg::EENTRY_VA_LSB-1:0]  eentry_va;
    logic [csr_pkg::XLEN-1:0]                         merged;
    logic                                             addr_err;

    // rdata is the current value of the addressed register
    assign merged   = (bus.wmask & bus.wvalue) | (~bus.wmask & rdata);
    assign addr_err = exc.ecode == csr_pkg::ECODE_ALE || exc.ecode == csr_pkg::ECODE_ADE;

    // exception first, then ertn, then software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (exc.ex) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (exc.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (bus.we && bus.num == csr_pkg::CSR_CRMD) begin
            crmd_plv <= merged[csr_pkg::PLV_LSB +: csr_pkg::PLV_W];
            crmd_ie  <= merged[csr_pkg::IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (bus.we && bus.num == csr_pkg::CSR_PRMD) begin
            prmd_pplv <= merged[csr_pkg::PLV_LSB +: csr_pkg::PLV_W];
            prmd_pie  <= merged[csr_pkg::IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie  <= '0;
            estat_swi <= '0;
        end else if (bus.we && bus.num == csr_pkg::CSR_ECFG) begin
            ecfg_lie <= merged[csr_pkg::INT_W-1:0] & csr_pkg::LIE_MASK;
        end else if (bus.we && bus.num == csr_pkg::CSR_ESTAT) begin
            estat_swi <= merged[csr_pkg::SWI_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (exc.ex) begin
            estat_ecode    <= exc.ecode;
            estat_esubcode <= exc.esubcode;
            era            <= exc.pc;
        end else if (bus.we && bus.num == csr_pkg::CSR_ERA) begin
            era <= merged;
        end
        if (exc.ex && addr_err)
            badv <= exc.vaddr;
        else if (bus.we && bus.num == csr_pkg::CSR_BADV)
            badv <= merged;
        if (bus.we && bus.num == csr_pkg::CSR_EENTRY)
            eentry_va <= merged[csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB];
    end

    // hw and ipi lines are not wired, they read zero
    always_comb begin
        estat_is = '0;
        estat_is[csr_pkg::SWI_W-1:0] = estat_swi;
        estat_is[csr_pkg::TI_BIT]    = ti_pending;
    end

    assign has_int    = (|(estat_is[csr_pkg::TI_BIT:0] & ecfg_lie[csr_pkg::TI_BIT:0])) & crmd_ie;
    assign ex_entry   = {eentry_va, {csr_pkg::EENTRY_VA_LSB{1'b0}}};
    assign ertn_entry = era;

    always_comb begin
        rdata = '0;
        case (bus.num)
            csr_pkg::CSR_CRMD: begin
                rdata[csr_pkg::PLV_LSB +: csr_pkg::PLV_W] = crmd_plv;
                rdata[csr_pkg::IE_BIT]                    = crmd_ie;
            end
            csr_pkg::CSR_PRMD: begin
                rdata[csr_pkg::PLV_LSB +: csr_pkg::PLV_W] = prmd_pplv;
                rdata[csr_pkg::IE_BIT]                    = prmd_pie;
            end
            csr_pkg::CSR_ECFG:   rdata[csr_pkg::INT_W-1:0] = ecfg_lie;
            csr_pkg::CSR_ESTAT: begin
                rdata[csr_pkg::INT_W-1:0] = estat_is;
                rdata[csr_pkg::ESTAT_ECODE_LSB +: csr_pkg::ECODE_W] = estat_ecode;
                rdata[csr_pkg::ESTAT_ESUBCODE_LSB +: csr_pkg::ESUBCODE_W] = estat_esubcode;
            end
            csr_pkg::CSR_ERA:    rdata = era;
            csr_pkg::CSR_BADV:   rdata = badv;
            csr_pkg::CSR_EENTRY: rdata = ex_entry;
            default:             rdata = '0;
        endcase
    end

    // writeback never flags both in one cycle
    assert property (@(posedge clk) disable iff (reset) !(exc.ex && exc.ertn));

endmodule

//--- verilog/exc_if.sv
`timescale 1ns/1ns

// exception and ertn events from writeback
interface exc_if;
    logic                           ex;
    logic                           ertn;
    logic [csr_pkg::ECODE_W-1:0]    ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] esubcode;
    logic [csr_pkg::XLEN-1:0]       pc;
    logic [csr_pkg::XLEN-1:0]       vaddr;

    modport source (
        output ex, ertn, ecode, esubcode, pc, vaddr
    );

    modport sink (
        input ex, ertn, ecode, esubcode, pc, vaddr
    );
endinterface

//--- verilog/csr_bus_if.sv
`timescale 1ns/1ns

// csr access from the pipeline, shared by all register blocks
interface csr_bus_if;
    logic [csr_pkg::CSR_NUM_W-1:0] num;
    logic                          we;
    logic [csr_pkg::XLEN-1:0]      wmask;
    logic [csr_pkg::XLEN-1:0]      wvalue;

    modport master (
        output num, we, wmask, wvalue
    );

    modport slave (
        input num, we, wmask, wvalue
    );
endinterface

//--- verilog/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_NUM_W  = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int PLV_W      = 2;
    localparam int INT_W      = 13;

    localparam logic [CSR_NUM_W-1:0] CSR_CRMD      = 14'h0;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD      = 14'h1;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG      = 14'h4;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT     = 14'h5;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA       = 14'h6;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV      = 14'h7;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY    = 14'hc;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE_BASE = 14'h30;
    localparam logic [CSR_NUM_W-1:0] CSR_TID       = 14'h40;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG      = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL      = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR     = 14'h44;

    // crmd and prmd share these positions
    localparam int PLV_LSB = 0;
    localparam int IE_BIT  = 2;

    // estat fields, is sits at bit 0 like ecfg lie
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;
    localparam int TI_BIT             = 11;
    localparam int SWI_W              = 2;  // software interrupt bits 1..0

    localparam int EENTRY_VA_LSB = 6;

    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;

    localparam logic [INT_W-1:0] LIE_MASK = 13'h1bff;  // bit 10 reserved

    localparam logic [ECODE_W-1:0] ECODE_ADE = 6'h8;
    localparam logic [ECODE_W-1:0] ECODE_ALE = 6'h9;

    localparam logic [XLEN-1:0] TIMER_IDLE = '1;

    localparam int SAVE_COUNT_MAX = 16;

endpackage
